// File: hw/i3c_ccc_pkg.sv
// Shared CCC codes, field kinds, limit type and queue-size positions for the CCC path
package i3c_ccc_pkg;

  // Supported command codes
  typedef enum logic [7:0] {
    SETMWL_B = 8'h09,
    SETMRL_B = 8'h0A,
    RSTACT_B = 8'h2A,
    SETMWL_D = 8'h89,
    SETMRL_D = 8'h8A,
    GETMWL   = 8'h8B,
    GETMRL   = 8'h8C
  } ccc_code_e;

  // Set for direct codes, clear for broadcast
  localparam int unsigned CCC_DIRECT_BIT = 7;

  // Role of a byte within a frame
  typedef enum logic [1:0] {
    FIELD_CODE     = 2'd0,
    FIELD_DEFINING = 2'd1,
    FIELD_DATA     = 2'd2
  } field_kind_e;

  // Buffer size bytes in queue_size_reg_i, counted in words
  localparam int unsigned QSZ_TX_MSB = 31;
  localparam int unsigned QSZ_RX_MSB = 23;

  // Write and read length limits, in bytes
  typedef logic [15:0] len_t;

  // Longest response held by the responder
  localparam int unsigned RESP_MAX_BYTES = 2;

  // Only RSTACT carries a defining byte in this command set
  function automatic logic ccc_has_defining_byte(logic [7:0] code);
    return code == RSTACT_B;
  endfunction

endpackage

// File: hw/ccc_field_if.sv
// Classified frame fields passed from the framer to the decoder, one per strobe
`timescale 1ns/1ps

interface ccc_field_if
  import i3c_ccc_pkg::*;
();

  // One-cycle strobe, no back-pressure
  logic        field_valid;
  field_kind_e kind;
  logic [7:0]  data;
  // Data bytes seen before this one in the frame, saturating
  logic [1:0]  data_index;
  logic        frame_open;
  // Delayed copy of the frame start pulse
  logic        flush;

  modport framer (
    output field_valid,
    output kind,
    output data,
    output data_index,
    output frame_open,
    output flush
  );

  modport decoder (
    input field_valid,
    input kind,
    input data,
    input data_index,
    input frame_open,
    input flush
  );

endinterface

// File: hw/ccc_resp_if.sv
// Response load and flush from the decoder to the responder
`timescale 1ns/1ps

interface ccc_resp_if;

  logic        load;
  // Most significant byte goes out first
  logic [15:0] bytes;
  // Number of valid bytes, 0 to 2
  logic [1:0]  length;
  logic        flush;

  modport decoder (
    output load,
    output bytes,
    output length,
    output flush
  );

  modport responder (
    input load,
    input bytes,
    input length,
    input flush
  );

endinterface

// File: hw/ccc_framer.sv
// First CCC stage, tags each received byte as code, defining byte or data
`timescale 1ns/1ps

module ccc_framer
  import i3c_ccc_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic [7:0] rx_byte_i,
  input  logic       rx_valid_i,
  input  logic       frame_start_i,
  input  logic       frame_stop_i,
  ccc_field_if.framer field_o
);

  logic        open_q;
  logic [1:0]  pos_q;
  logic [7:0]  code_q;
  logic [1:0]  data_cnt_q;
  logic        accept;
  field_kind_e kind_d;

  logic        field_valid_q;
  field_kind_e kind_q;
  logic [7:0]  data_q;
  logic [1:0]  data_index_q;
  logic        flush_q;

  // A byte on the start cycle belongs to no frame
  assign accept = rx_valid_i && open_q && !frame_start_i;

  // Position in the frame decides the field kind
  always_comb begin
    if (pos_q == 2'd0) begin
      kind_d = FIELD_CODE;
    end else if (pos_q == 2'd1 && ccc_has_defining_byte(code_q)) begin
      kind_d = FIELD_DEFINING;
    end else begin
      kind_d = FIELD_DATA;
    end
  end

  // Frame state
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      open_q     <= 1'b0;
      pos_q      <= 2'd0;
      code_q     <= 8'h00;
      data_cnt_q <= 2'd0;
    end else if (frame_start_i) begin
      open_q     <= 1'b1;
      pos_q      <= 2'd0;
      data_cnt_q <= 2'd0;
    end else begin
      if (frame_stop_i) begin
        open_q <= 1'b0;
      end
      if (accept) begin
        if (pos_q != 2'd2) begin
          pos_q <= pos_q + 2'd1;
        end
        if (kind_d == FIELD_CODE) begin
          code_q <= rx_byte_i;
        end
        // Saturates so long frames do not wrap
        if (kind_d == FIELD_DATA && data_cnt_q != 2'd3) begin
          data_cnt_q <= data_cnt_q + 2'd1;
        end
      end
    end
  end

  // Strobes
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      field_valid_q <= 1'b0;
      flush_q       <= 1'b0;
    end else begin
      field_valid_q <= accept;
      flush_q       <= frame_start_i;
    end
  end

  // Field payload
  always_ff @(posedge clk_i) begin
    if (accept) begin
      kind_q       <= kind_d;
      data_q       <= rx_byte_i;
      data_index_q <= data_cnt_q;
    end
  end

  assign field_o.field_valid = field_valid_q;
  assign field_o.kind        = kind_q;
  assign field_o.data        = data_q;
  assign field_o.data_index  = data_index_q;
  assign field_o.frame_open  = open_q;
  assign field_o.flush       = flush_q;

endmodule

// File: hw/ccc_decoder.sv
// Second CCC stage, latches fields, keeps the negotiated limits and builds GET responses
`timescale 1ns/1ps

module ccc_decoder
  import i3c_ccc_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  ccc_field_if.decoder field_i,
  input  logic [31:0] queue_size_reg_i,
  ccc_resp_if.decoder resp_o,
  output len_t        max_write_len_o,
  output len_t        max_read_len_o,
  output logic [7:0]  rst_action_o
);

  ccc_code_e  code_q;
  logic       active_q;
  logic [7:0] data_hi_q;
  logic [7:0] rst_action_q;

  logic       mwl_set_q;
  logic       mrl_set_q;
  len_t       mwl_q;
  len_t       mrl_q;

  logic       load_q;
  len_t       resp_bytes_q;
  logic       flush_q;

  logic [7:0] tx_size;
  logic [7:0] rx_size;
  len_t       default_mwl;
  len_t       default_mrl;

  logic       code_fire;
  logic       def_fire;
  logic       data_fire;
  logic       is_setmwl;
  logic       is_setmrl;
  logic       get_hit;
  len_t       get_len;

  // Sizes count words, limits count bytes
  assign tx_size     = queue_size_reg_i[QSZ_TX_MSB -: 8];
  assign rx_size     = queue_size_reg_i[QSZ_RX_MSB -: 8];
  assign default_mwl = {6'd0, rx_size, 2'b00};
  assign default_mrl = {6'd0, tx_size, 2'b00};

  assign code_fire = field_i.field_valid && field_i.kind == FIELD_CODE;
  assign def_fire  = field_i.field_valid && field_i.kind == FIELD_DEFINING && active_q;
  assign data_fire = field_i.field_valid && field_i.kind == FIELD_DATA && active_q;

  // Broadcast and direct forms update the same limit
  assign is_setmwl = code_q == SETMWL_B || code_q == SETMWL_D;
  assign is_setmrl = code_q == SETMRL_B || code_q == SETMRL_D;

  // GETs are direct only, so broadcast codes never answer
  always_comb begin
    get_hit = 1'b0;
    get_len = max_write_len_o;
    if (code_fire && field_i.data[CCC_DIRECT_BIT]) begin
      if (field_i.data == GETMWL) begin
        get_hit = 1'b1;
        get_len = max_write_len_o;
      end else if (field_i.data == GETMRL) begin
        get_hit = 1'b1;
        get_len = max_read_len_o;
      end
    end
  end

  // Command latch, dropped when the frame closes or restarts
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      code_q   <= ccc_code_e'(8'h00);
      active_q <= 1'b0;
    end else if (code_fire) begin
      code_q   <= ccc_code_e'(field_i.data);
      active_q <= 1'b1;
    end else if (field_i.flush || (!field_i.frame_open && !field_i.field_valid)) begin
      active_q <= 1'b0;
    end
  end

  // High data byte waits for the low one
  always_ff @(posedge clk_i) begin
    if (data_fire && field_i.data_index == 2'd0) begin
      data_hi_q <= field_i.data;
    end
  end

  // Limit and reset-action registers
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mwl_set_q    <= 1'b0;
      mrl_set_q    <= 1'b0;
      mwl_q        <= '0;
      mrl_q        <= '0;
      rst_action_q <= 8'h00;
    end else begin
      if (data_fire && field_i.data_index == 2'd1) begin
        if (is_setmwl) begin
          mwl_set_q <= 1'b1;
          mwl_q     <= {data_hi_q, field_i.data};
        end
        if (is_setmrl) begin
          mrl_set_q <= 1'b1;
          mrl_q     <= {data_hi_q, field_i.data};
        end
      end
      if (def_fire && code_q == RSTACT_B) begin
        rst_action_q <= field_i.data;
      end
    end
  end

  // Response strobes
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      load_q  <= 1'b0;
      flush_q <= 1'b0;
    end else begin
      load_q  <= get_hit;
      flush_q <= field_i.flush;
    end
  end

  always_ff @(posedge clk_i) begin
    if (get_hit) begin
      resp_bytes_q <= get_len;
    end
  end

  // Queue size default holds until a SET arrives
  assign max_write_len_o = mwl_set_q ? mwl_q : default_mwl;
  assign max_read_len_o  = mrl_set_q ? mrl_q : default_mrl;
  assign rst_action_o    = rst_action_q;

  assign resp_o.load   = load_q;
  assign resp_o.bytes  = resp_bytes_q;
  assign resp_o.length = 2'(RESP_MAX_BYTES);
  assign resp_o.flush  = flush_q;

endmodule

// File: hw/ccc_responder.sv
// Third CCC stage, holds a response and hands out one byte per read request
`timescale 1ns/1ps

module ccc_responder
  import i3c_ccc_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  ccc_resp_if.responder resp_i,
  input  logic       tx_req_i,
  output logic [7:0] tx_byte_o,
  output logic       tx_valid_o
);

  // Head byte sits in the top slot
  logic [RESP_MAX_BYTES-1:0][7:0] shreg_q;
  logic [1:0]                     cnt_q;
  logic                           advance;

  // Requests with nothing left are ignored
  assign advance = tx_req_i && cnt_q != 2'd0;

  // Remaining byte count
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= 2'd0;
    end else if (resp_i.load) begin
      // Newest response wins over a pending flush
      cnt_q <= resp_i.length;
    end else if (resp_i.flush) begin
      cnt_q <= 2'd0;
    end else if (advance) begin
      cnt_q <= cnt_q - 2'd1;
    end
  end

  // Response bytes
  always_ff @(posedge clk_i) begin
    if (resp_i.load) begin
      shreg_q <= resp_i.bytes;
    end else if (advance) begin
      shreg_q <= {shreg_q[RESP_MAX_BYTES-2:0], 8'h00};
    end
  end

  assign tx_byte_o  = shreg_q[RESP_MAX_BYTES-1];
  assign tx_valid_o = cnt_q != 2'd0;

endmodule

// File: hw/i3c_ccc_top.sv
// Top level of the I3C target CCC path, chains framer, decoder and responder
`timescale 1ns/1ps

module i3c_ccc_top
  import i3c_ccc_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  // Byte stream from the bus receiver
  input  logic [7:0]  rx_byte_i,
  input  logic        rx_valid_i,
  input  logic        frame_start_i,
  input  logic        frame_stop_i,
  // Buffer sizes for the default limits
  input  logic [31:0] queue_size_reg_i,
  // Read data toward the controller
  input  logic        tx_req_i,
  output logic [7:0]  tx_byte_o,
  output logic        tx_valid_o,
  // Negotiated state
  output len_t        max_write_len_o,
  output len_t        max_read_len_o,
  output logic [7:0]  rst_action_o
);

  ccc_field_if field_if ();
  ccc_resp_if  resp_if ();

  ccc_framer i_framer (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .rx_byte_i     (rx_byte_i),
    .rx_valid_i    (rx_valid_i),
    .frame_start_i (frame_start_i),
    .frame_stop_i  (frame_stop_i),
    .field_o       (field_if.framer)
  );

  ccc_decoder i_decoder (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .field_i          (field_if.decoder),
    .queue_size_reg_i (queue_size_reg_i),
    .resp_o           (resp_if.decoder),
    .max_write_len_o  (max_write_len_o),
    .max_read_len_o   (max_read_len_o),
    .rst_action_o     (rst_action_o)
  );

  ccc_responder i_responder (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .resp_i     (resp_if.responder),
    .tx_req_i   (tx_req_i),
    .tx_byte_o  (tx_byte_o),
    .tx_valid_o (tx_valid_o)
  );

endmodule

// File: test/tb_i3c_ccc_top.sv
// Replays the CCC pattern file against the CCC path top level and checks each expected value
`timescale 1ns/1ps

module tb_i3c_ccc_top
  import i3c_ccc_pkg::*;
();

  localparam int RESET_CYCLES    = 16;
  localparam int CYCLES_PER_LINE = 20;

  logic        clk_i = 1'b0;
  logic        rst_ni;
  logic [7:0]  rx_byte_i;
  logic        rx_valid_i;
  logic        frame_start_i;
  logic        frame_stop_i;
  logic [31:0] queue_size_reg_i;
  logic        tx_req_i;
  logic [7:0]  tx_byte_o;
  logic        tx_valid_o;
  len_t        max_write_len_o;
  len_t        max_read_len_o;
  logic [7:0]  rst_action_o;

  // Operation letter and hex value of each pattern line
  logic [7:0]  op_q[$];
  logic [31:0] val_q[$];
  logic        loaded;

  i3c_ccc_top i_dut (.*);

  always #50 clk_i = ~clk_i;

  task automatic compare_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      $display("FAILED %s expected 0x%02h actual 0x%02h", name, exp, act);
      $display("TEST FAIL");
      $fatal(1, "Byte value mismatch");
    end
  endtask

  task automatic compare_len(input string name, input len_t exp, input len_t act);
    if (act !== exp) begin
      $display("FAILED %s expected 0x%04h actual 0x%04h", name, exp, act);
      $display("TEST FAIL");
      $fatal(1, "Length value mismatch");
    end
  endtask

  task automatic compare_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAILED %s expected 0x%0h actual 0x%0h", name, exp, act);
      $display("TEST FAIL");
      $fatal(1, "Flag value mismatch");
    end
  endtask

  // Inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic run_op(input logic [7:0] op, input logic [31:0] val);
    case (op)
      "Q": begin
        queue_size_reg_i = val;
        next_cycle();
      end
      "S": begin
        frame_start_i = 1'b1;
        next_cycle();
        frame_start_i = 1'b0;
      end
      "B": begin
        rx_byte_i  = val[7:0];
        rx_valid_i = 1'b1;
        next_cycle();
        rx_valid_i = 1'b0;
      end
      "P": begin
        frame_stop_i = 1'b1;
        next_cycle();
        frame_stop_i = 1'b0;
      end
      // Check the head byte, then take it
      "R": begin
        compare_flag("tx_valid_o", 1'b1, tx_valid_o);
        compare_byte("tx_byte_o", val[7:0], tx_byte_o);
        tx_req_i = 1'b1;
        next_cycle();
        tx_req_i = 1'b0;
      end
      "W": compare_len("max_write_len_o", val[15:0], max_write_len_o);
      "L": compare_len("max_read_len_o", val[15:0], max_read_len_o);
      "A": compare_byte("rst_action_o", val[7:0], rst_action_o);
      "E": compare_flag("tx_valid_o", 1'b0, tx_valid_o);
      "I": repeat (val) next_cycle();
      default: begin
        $display("Pattern file holds an unknown operation %c", op);
        $display("TEST FAIL");
        $fatal(1, "Bad pattern line");
      end
    endcase
  endtask

  initial begin
    int          fd;
    string       line;
    logic [31:0] val;
    rst_ni           = 1'b0;
    rx_byte_i        = 8'h00;
    rx_valid_i       = 1'b0;
    frame_start_i    = 1'b0;
    frame_stop_i     = 1'b0;
    queue_size_reg_i = 32'h0;
    tx_req_i         = 1'b0;
    loaded           = 1'b0;
    fd = $fopen("test/ccc_patterns.txt", "r");
    if (fd == 0) begin
      $display("Could not open the pattern file test/ccc_patterns.txt");
      $display("TEST FAIL");
      $fatal(1, "Missing pattern file");
    end
    // Comment lines start with a hash
    while ($fgets(line, fd) > 0) begin
      if (line.len() > 1 && line.getc(0) != "#") begin
        val = 32'h0;
        void'($sscanf(line.substr(1, line.len() - 1), "%h", val));
        op_q.push_back(line.getc(0));
        val_q.push_back(val);
      end
    end
    $fclose(fd);
    loaded = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    foreach (op_q[i]) begin
      run_op(op_q[i], val_q[i]);
    end
    $display("TEST PASS");
    $finish;
  end

  // Budget grows with the number of pattern lines
  initial begin
    wait (loaded === 1'b1);
    repeat (RESET_CYCLES + CYCLES_PER_LINE * op_q.size()) @(posedge clk_i);
    $display("Timed out before all %0d pattern lines were replayed", op_q.size());
    $display("TEST FAIL");
    $fatal(1, "Watchdog expired");
  end

endmodule

// File: i3c_ccc_top.f
hw/i3c_ccc_pkg.sv
hw/ccc_field_if.sv
hw/ccc_resp_if.sv
hw/ccc_framer.sv
hw/ccc_decoder.sv
hw/ccc_responder.sv
hw/i3c_ccc_top.sv
test/tb_i3c_ccc_top.sv

// File: run_sim.sh
#!/bin/sh
# Builds the CCC path testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

verilator --binary --timing --timescale 1ns/1ps --top-module tb_i3c_ccc_top \
  -f i3c_ccc_top.f -o tb_i3c_ccc_top
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/tb_i3c_ccc_top
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit "$status"
fi

echo "Simulation finished"
exit 0

// File: test/ccc_patterns.txt
# Columns: op letter, hex value. Drives Q queue reg, S start, B byte, P stop, I idle cycles
# Checks R read byte, W write limit, L read limit, A reset action, E tx_valid low
Q 10200000
W 0080
L 0040
E 0
A 00
S 0
B 09
B 01
B 23
P 0
S 0
B 8b
P 0
I 3
R 01
R 23
E 0
Q 08080000
W 0123
L 0020
S 0
B 8a
B 04
B 56
P 0
S 0
B 8c
P 0
I 3
R 04
R 56
E 0
S 0
B 2a
B 5a
B ff
B ee
P 0
A 5a
L 0456
S 0
B 8b
P 0
I 3
R 01
S 0
I 3
E 0
P 0
B 09
B ff
B ff
S 0
B 55
B 77
B 88
P 0
W 0123
